/* common/io_pkg.sv */
`default_nettype none

package io_pkg;

    // field widths
    localparam int cmd_w  = 16;
    localparam int op_w   = 4;
    localparam int grp_w  = 3;
    localparam int addr_w = 9;
    localparam int mode_w = 12;

    // opcodes
    localparam logic [op_w-1:0] op_nop      = 4'h0;
    localparam logic [op_w-1:0] op_pio_out  = 4'h5;
    localparam logic [op_w-1:0] op_discrete = 4'ha;

    localparam logic [grp_w-1:0] unit_group = 3'd6; // only group this unit answers

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // mode field bit positions, 8..11 reserved
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int mode_tlm_set  = 0;
    localparam int mode_tlm_clr  = 1;
    localparam int mode_mla_set  = 2;
    localparam int mode_mla_clr  = 3;
    localparam int mode_info_set = 4;
    localparam int mode_info_clr = 5;
    localparam int mode_ack_din  = 6;
    localparam int mode_ack_int  = 7;

    // one command word, two decodes; opcode shares the top nibble
    typedef union packed {
        struct packed {
            logic [op_w-1:0]   opcode;
            logic [grp_w-1:0]  group;
            logic [addr_w-1:0] addr;
        } adr;
        struct packed {
            logic [op_w-1:0]   opcode;
            logic [mode_w-1:0] mode;
        } disc;
    } io_cmd_u;

endpackage

`default_nettype wire

/* design/phase_gen.sv */
`default_nettype none

module phase_gen (
    input  logic sim_clk,
    input  logic rst_n,
    output logic w7,
    output logic x3,
    output logic y3,
    output logic z7
);

    logic [1:0] phase_cnt;

    // free running, wraps every word
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_cnt <= 2'd0;
        end else begin
            phase_cnt <= phase_cnt + 2'd1;
        end
    end

    // strobes lag the count by one cycle,
    // so w7 is the first cycle out of reset
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            w7 <= 1'b0;
            x3 <= 1'b0;
            y3 <= 1'b0;
            z7 <= 1'b0;
        end else begin
            w7 <= (phase_cnt == 2'd0);
            x3 <= (phase_cnt == 2'd1);
            y3 <= (phase_cnt == 2'd2);
            z7 <= (phase_cnt == 2'd3);
        end
    end

endmodule

`default_nettype wire

/* decode/cmd_field_decode.sv */
`default_nettype none

module cmd_field_decode (
    input  logic                        sim_clk,
    input  logic                        rst_n,
    input  logic                        cmd_strobe,
    input  io_pkg::io_cmd_u             cmd_word,
    input  logic                        w7,
    input  logic                        z7,
    output logic                        cmd_busy,
    output logic                        exec,
    output logic                        do_pio,
    output logic                        do_disc,
    output logic [io_pkg::addr_w-1:0]   cmd_addr,
    output logic [io_pkg::mode_w-1:0]   cmd_mode
);

    io_pkg::io_cmd_u cmd_q;     // pending command
    logic            run_q;     // inside execution word, past w7
    logic            accept;
    logic            is_pio_op;
    logic            is_disc_op;
    logic            grp_hit;

    assign accept = cmd_strobe & ~cmd_busy; // strobes while busy are dropped

    always_ff @(posedge sim_clk) begin
        if (accept) begin
            cmd_q <= cmd_word;
        end
    end

    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_busy <= 1'b0;
            run_q    <= 1'b0;
        end else begin
            if (accept) begin
                cmd_busy <= 1'b1;
            end else if (run_q && z7) begin
                cmd_busy <= 1'b0;   // word done, free next cycle
            end

            if (w7 && cmd_busy) begin
                run_q <= 1'b1;      // first w7 after capture
            end else if (z7) begin
                run_q <= 1'b0;
            end
        end
    end

    // w7 of the word itself, then the held flag for x3..z7
    assign exec = cmd_busy & (w7 | run_q);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign is_pio_op  = (cmd_q.disc.opcode == io_pkg::op_pio_out);
    assign is_disc_op = (cmd_q.disc.opcode == io_pkg::op_discrete);
    assign grp_hit    = (cmd_q.adr.group == io_pkg::unit_group);

    // nop and unknown opcodes still burn a word
    assign do_pio  = cmd_busy & is_pio_op & grp_hit;
    assign do_disc = cmd_busy & is_disc_op;

    assign cmd_addr = cmd_q.adr.addr;
    assign cmd_mode = cmd_q.disc.mode;

endmodule

`default_nettype wire

/* decode/address_decode.sv */
`default_nettype none

module address_decode (
    input  logic                        sim_clk,
    input  logic                        rst_n,
    input  logic                        w7,
    input  logic                        x3,
    input  logic                        y3,
    input  logic                        z7,
    input  logic                        exec,
    input  logic                        do_pio,
    input  logic                        do_disc,
    input  logic                        din_ready,
    input  logic                        sint,
    input  logic [io_pkg::addr_w-1:0]   cmd_addr,
    input  logic [io_pkg::mode_w-1:0]   cmd_mode,
    output logic [io_pkg::addr_w-1:0]   addr,
    output logic                        pio_d,
    output logic                        codg,
    output logic                        dainf,
    output logic                        dinf,
    output logic                        info,
    output logic                        tlm,
    output logic                        mla,
    output logic                        ocr
);

    logic pio_word;
    logic disc_act;     // discrete mode bits fire here

    assign pio_word = exec & do_pio;
    assign disc_act = exec & do_disc & z7;

    // set/clear pair, clear dominates
    function automatic logic sr_next(input logic q, input logic set, input logic clr);
        logic nxt;
        nxt = q;
        if (clr) begin
            nxt = 1'b0;
        end else if (set) begin
            nxt = 1'b1;
        end
        return nxt;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address register and pio
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            addr  <= '0;
            pio_d <= 1'b0;
            codg  <= 1'b0;
        end else if (pio_word) begin
            if (w7) begin
                addr  <= '0;        // clear before load
                pio_d <= 1'b0;
            end
            if (x3) begin
                addr <= cmd_addr;
            end
            if (y3) begin
                pio_d <= 1'b1;
            end
            // odd parity over register plus codg
            if (z7) begin
                codg <= ~^addr;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data-in and interrupt flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            dainf <= 1'b0;
            dinf  <= 1'b0;
        end else begin
            // set on w7, ack on z7, never together
            if (w7 && din_ready) begin
                dainf <= 1'b1;
            end else if (disc_act && cmd_mode[io_pkg::mode_ack_din]) begin
                dainf <= 1'b0;
            end
            if (y3) begin
                dinf <= dainf;      // second stage
            end
        end
    end

    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            ocr <= 1'b0;
        end else if (z7 && sint) begin
            ocr <= 1'b1;            // request wins over ack
        end else if (disc_act && cmd_mode[io_pkg::mode_ack_int]) begin
            ocr <= 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // mode latches
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            tlm  <= 1'b0;
            mla  <= 1'b0;
            info <= 1'b0;
        end else if (disc_act) begin
            tlm  <= sr_next(tlm, cmd_mode[io_pkg::mode_tlm_set],
                            cmd_mode[io_pkg::mode_tlm_clr]);
            mla  <= sr_next(mla, cmd_mode[io_pkg::mode_mla_set],
                            cmd_mode[io_pkg::mode_mla_clr]);
            info <= sr_next(info, cmd_mode[io_pkg::mode_info_set],
                            cmd_mode[io_pkg::mode_info_clr]);
        end
    end

endmodule

`default_nettype wire

/* design/io_unit_top.sv */
`default_nettype none

module io_unit_top (
    input  logic                        sim_clk,
    input  logic                        rst_n,
    input  logic                        cmd_strobe,
    input  logic                        din_ready,
    input  logic                        sint,
    input  logic [io_pkg::cmd_w-1:0]    cmd_word,
    output logic                        cmd_busy,
    output logic                        word_sync,
    output logic                        pio_d,
    output logic                        codg,
    output logic                        dainf,
    output logic                        dinf,
    output logic                        info,
    output logic                        tlm,
    output logic                        mla,
    output logic                        ocr,
    output logic [io_pkg::addr_w-1:0]   addr
);

    // word_sync doubles as the w7 strobe
    logic                       x3;
    logic                       y3;
    logic                       z7;
    logic                       exec;
    logic                       do_pio;
    logic                       do_disc;
    logic [io_pkg::addr_w-1:0]  cmd_addr;
    logic [io_pkg::mode_w-1:0]  cmd_mode;

    phase_gen i_phase_gen (
        .sim_clk (sim_clk),
        .rst_n   (rst_n),
        .w7      (word_sync),
        .x3      (x3),
        .y3      (y3),
        .z7      (z7)
    );

    cmd_field_decode i_cmd_field_decode (
        .sim_clk    (sim_clk),
        .rst_n      (rst_n),
        .cmd_strobe (cmd_strobe),
        .cmd_word   (cmd_word),
        .w7         (word_sync),
        .z7         (z7),
        .cmd_busy   (cmd_busy),
        .exec       (exec),
        .do_pio     (do_pio),
        .do_disc    (do_disc),
        .cmd_addr   (cmd_addr),
        .cmd_mode   (cmd_mode)
    );

    address_decode i_address_decode (
        .sim_clk   (sim_clk),
        .rst_n     (rst_n),
        .w7        (word_sync),
        .x3        (x3),
        .y3        (y3),
        .z7        (z7),
        .exec      (exec),
        .do_pio    (do_pio),
        .do_disc   (do_disc),
        .din_ready (din_ready),
        .sint      (sint),
        .cmd_addr  (cmd_addr),
        .cmd_mode  (cmd_mode),
        .addr      (addr),
        .pio_d     (pio_d),
        .codg      (codg),
        .dainf     (dainf),
        .dinf      (dinf),
        .info      (info),
        .tlm       (tlm),
        .mla       (mla),
        .ocr       (ocr)
    );

endmodule

`default_nettype wire

/* verification/io_unit_props.sv */
`default_nettype none

module io_unit_props (
    input logic                         sim_clk,
    input logic                         rst_n,
    input logic                         cmd_strobe,
    input logic                         cmd_busy,
    input logic                         word_sync,
    input logic                         y3,
    input logic                         z7,
    input logic                         exec,
    input logic                         do_disc,
    input logic                         sint,
    input logic [io_pkg::mode_w-1:0]    cmd_mode,
    input logic [io_pkg::addr_w-1:0]    addr,
    input logic                         pio_d,
    input logic                         codg,
    input logic                         dainf,
    input logic                         dinf,
    input logic                         ocr
);

    timeunit 1ns;
    timeprecision 100ps;

    int         fail_cnt = 0;   // read by the testbench
    logic [1:0] since_sync;
    logic [3:0] busy_run;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helper counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge sim_clk or negedge rst_n) begin
        if (!rst_n) begin
            since_sync <= 2'd2;     // first w7 comes one cycle after release
            busy_run   <= 4'd0;
        end else begin
            since_sync <= word_sync ? 2'd0 : since_sync + 2'd1;
            busy_run   <= cmd_busy ? busy_run + 4'd1 : 4'd0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // properties
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    sync_period: assert property (@(posedge sim_clk) disable iff (!rst_n)
        word_sync == (since_sync == 2'd3))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("word_sync off its 4-cycle period");
        end

    busy_rise: assert property (@(posedge sim_clk) disable iff (!rst_n)
        cmd_strobe && !cmd_busy |=> cmd_busy)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("cmd_busy missed an accepted strobe");
        end

    busy_bound: assert property (@(posedge sim_clk) disable iff (!rst_n)
        cmd_busy |-> busy_run < 4'd8)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("cmd_busy held too long");
        end

    addr_parity: assert property (@(posedge sim_clk) disable iff (!rst_n)
        pio_d && !cmd_busy |-> ^{addr, codg})
        else begin
            fail_cnt = fail_cnt + 1;
            $error("address parity is even");
        end

    dainf_hold: assert property (@(posedge sim_clk) disable iff (!rst_n)
        dainf && !(exec && do_disc && z7 && cmd_mode[io_pkg::mode_ack_din]) |=> dainf)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("dainf dropped without ack");
        end

    ocr_set: assert property (@(posedge sim_clk) disable iff (!rst_n)
        z7 && sint |=> ocr)
        else begin
            fail_cnt = fail_cnt + 1;
            $error("ocr not set by sint at z7");
        end

    dinf_copy: assert property (@(posedge sim_clk) disable iff (!rst_n)
        y3 |=> dinf == $past(dainf))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("dinf did not copy dainf at y3");
        end

    dinf_keep: assert property (@(posedge sim_clk) disable iff (!rst_n)
        !y3 |=> $stable(dinf))
        else begin
            fail_cnt = fail_cnt + 1;
            $error("dinf moved outside y3");
        end

endmodule

bind io_unit_top io_unit_props i_io_unit_props (
    .sim_clk    (sim_clk),
    .rst_n      (rst_n),
    .cmd_strobe (cmd_strobe),
    .cmd_busy   (cmd_busy),
    .word_sync  (word_sync),
    .y3         (y3),
    .z7         (z7),
    .exec       (exec),
    .do_disc    (do_disc),
    .sint       (sint),
    .cmd_mode   (cmd_mode),
    .addr       (addr),
    .pio_d      (pio_d),
    .codg       (codg),
    .dainf      (dainf),
    .dinf       (dinf),
    .ocr        (ocr)
);

`default_nettype wire

/* verification/tb_io_unit.sv */
`default_nettype none

module tb_io_unit;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_directed  = 10;
    localparam int n_cmds      = 60;
    localparam int cycle_limit = n_cmds * 8 + 200;

    logic                       sim_clk = 1'b0;
    logic                       rst_n;
    logic                       cmd_strobe;
    logic                       din_ready;
    logic                       sint;
    logic [io_pkg::cmd_w-1:0]   cmd_word;
    logic                       cmd_busy;
    logic                       word_sync;
    logic                       pio_d;
    logic                       codg;
    logic                       dainf;
    logic                       dinf;
    logic                       info;
    logic                       tlm;
    logic                       mla;
    logic                       ocr;
    logic [io_pkg::addr_w-1:0]  addr;

    integer seed;
    int     cycle_cnt = 0;

    // expected state
    logic [io_pkg::addr_w-1:0]  exp_addr;
    logic                       exp_pio_d;
    logic                       exp_codg;
    logic                       exp_dainf;
    logic                       exp_ocr;
    logic                       exp_tlm;
    logic                       exp_mla;
    logic                       exp_info;

    io_unit_top i_io_unit_top (
        .sim_clk    (sim_clk),
        .rst_n      (rst_n),
        .cmd_strobe (cmd_strobe),
        .din_ready  (din_ready),
        .sint       (sint),
        .cmd_word   (cmd_word),
        .cmd_busy   (cmd_busy),
        .word_sync  (word_sync),
        .pio_d      (pio_d),
        .codg       (codg),
        .dainf      (dainf),
        .dinf       (dinf),
        .info       (info),
        .tlm        (tlm),
        .mla        (mla),
        .ocr        (ocr),
        .addr       (addr)
    );

    always #5 sim_clk = ~sim_clk;

    task automatic stop_on_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge sim_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            stop_on_error($sformatf("run did not finish within %0d cycles", cycle_limit));
        end
    end

    always @(negedge sim_clk) begin
        if (i_io_unit_top.i_io_unit_props.fail_cnt != 0) begin
            stop_on_error("a bound property check failed");
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command builders
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [io_pkg::mode_w-1:0] mode_mask(input int pos);
        return 12'd1 << pos;
    endfunction

    function automatic io_pkg::io_cmd_u pio_cmd(input logic [2:0] grp, input logic [8:0] a);
        io_pkg::io_cmd_u w;
        w.adr.opcode = io_pkg::op_pio_out;
        w.adr.group  = grp;
        w.adr.addr   = a;
        return w;
    endfunction

    function automatic io_pkg::io_cmd_u disc_cmd(input logic [io_pkg::mode_w-1:0] m);
        io_pkg::io_cmd_u w;
        w.disc.opcode = io_pkg::op_discrete;
        w.disc.mode   = m;
        return w;
    endfunction

    function automatic io_pkg::io_cmd_u random_cmd();
        logic [31:0]     rnd;
        io_pkg::io_cmd_u w;
        rnd = $random(seed);
        w   = rnd[15:0];    // pattern 3 keeps a random opcode
        if (rnd[17:16] == 2'd0) begin
            w.disc.opcode = io_pkg::op_nop;
        end else if (rnd[17:16] == 2'd1) begin
            w.adr.opcode = io_pkg::op_pio_out;
            if (rnd[18]) begin
                w.adr.group = io_pkg::unit_group;   // else some other group
            end
        end else if (rnd[17:16] == 2'd2) begin
            w.disc.opcode = io_pkg::op_discrete;
        end
        return w;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic update_model(input io_pkg::io_cmd_u w, input logic din, input logic si);
        logic [io_pkg::mode_w-1:0] m;
        m = w.disc.mode;
        exp_dainf = exp_dainf | din;    // exec w7 sees din held
        exp_ocr   = exp_ocr | si;
        if (w.adr.opcode == io_pkg::op_pio_out && w.adr.group == io_pkg::unit_group) begin
            exp_addr  = w.adr.addr;
            exp_pio_d = 1'b1;
            exp_codg  = ($countones(w.adr.addr) % 2 == 0);  // odd ones over addr and codg
        end else if (w.disc.opcode == io_pkg::op_discrete) begin
            exp_tlm  = m[io_pkg::mode_tlm_clr] ? 1'b0 : (exp_tlm | m[io_pkg::mode_tlm_set]);
            exp_mla  = m[io_pkg::mode_mla_clr] ? 1'b0 : (exp_mla | m[io_pkg::mode_mla_set]);
            exp_info = m[io_pkg::mode_info_clr] ? 1'b0 :
                       (exp_info | m[io_pkg::mode_info_set]);
            if (m[io_pkg::mode_ack_din]) begin
                exp_dainf = 1'b0;
            end
            if (m[io_pkg::mode_ack_int]) begin
                exp_ocr = si;           // sint at z7 beats the ack
            end
        end
    endtask

    task automatic check_state(input int idx);
        logic [6:0] got;
        logic [6:0] want;
        got  = {pio_d, codg, dainf, ocr, tlm, mla, info};
        want = {exp_pio_d, exp_codg, exp_dainf, exp_ocr, exp_tlm, exp_mla, exp_info};
        assert (addr === exp_addr && got === want) else stop_on_error(
            $sformatf("command %0d: addr %h flags %b, expected addr %h flags %b",
                      idx, addr, got, exp_addr, want));
    endtask

    // called at the negedge of a w7 cycle with cmd_busy low
    task automatic send_cmd(input int idx, input io_pkg::io_cmd_u w, input logic din,
                            input logic si, input logic [1:0] gap, input logic poke);
        logic [31:0] rnd;
        exp_dainf = exp_dainf | din_ready;  // this w7 still uses the old level
        if (gap == 2'd3) begin
            exp_ocr = exp_ocr | sint;       // one idle z7 before the strobe
        end
        repeat (gap) @(posedge sim_clk);
        @(posedge sim_clk);
        cmd_strobe <= 1'b1;
        cmd_word   <= w;
        din_ready  <= din;
        sint       <= si;
        @(posedge sim_clk);
        cmd_strobe <= 1'b0;
        @(negedge sim_clk);
        assert (cmd_busy) else stop_on_error($sformatf("command %0d: cmd_busy low", idx));
        if (poke) begin
            rnd = $random(seed);
            @(posedge sim_clk);
            cmd_strobe <= 1'b1;             // must be dropped
            cmd_word   <= rnd[15:0];
            @(posedge sim_clk);
            cmd_strobe <= 1'b0;
        end
        do begin
            @(negedge sim_clk);
        end while (cmd_busy);
        update_model(w, din, si);
        check_state(idx);
    endtask

    initial begin
        logic [31:0] rnd;
        seed       = 32'hf53c_bf63;
        rst_n      <= 1'b0;
        cmd_strobe <= 1'b0;
        cmd_word   <= '0;
        din_ready  <= 1'b0;
        sint       <= 1'b0;
        exp_addr   = '0;
        exp_pio_d  = 1'b0;
        exp_codg   = 1'b0;
        exp_dainf  = 1'b0;
        exp_ocr    = 1'b0;
        exp_tlm    = 1'b0;
        exp_mla    = 1'b0;
        exp_info   = 1'b0;

        repeat (5) @(posedge sim_clk);
        rst_n <= 1'b1;
        @(negedge sim_clk);
        assert ({cmd_busy, word_sync, addr, pio_d, codg, dainf, dinf, info, tlm, mla, ocr}
                === '0) else stop_on_error("outputs not all zero after reset");
        do begin
            @(negedge sim_clk);
        end while (!word_sync);

        // directed
        send_cmd(0, pio_cmd(io_pkg::unit_group, 9'h1a5), 1'b0, 1'b0, 2'd0, 1'b0);
        send_cmd(1, pio_cmd(io_pkg::unit_group, 9'h000), 1'b0, 1'b0, 2'd1, 1'b0);
        send_cmd(2, pio_cmd(3'd2, 9'h0ff), 1'b0, 1'b0, 2'd2, 1'b0);
        send_cmd(3, disc_cmd(mode_mask(io_pkg::mode_tlm_set) | mode_mask(io_pkg::mode_mla_set)
                 | mode_mask(io_pkg::mode_info_set)), 1'b1, 1'b1, 2'd3, 1'b0);
        send_cmd(4, disc_cmd(mode_mask(io_pkg::mode_tlm_set) | mode_mask(io_pkg::mode_tlm_clr)
                 | mode_mask(io_pkg::mode_info_clr)), 1'b1, 1'b1, 2'd0, 1'b1);
        send_cmd(5, disc_cmd(mode_mask(io_pkg::mode_ack_din) | mode_mask(io_pkg::mode_ack_int)),
                 1'b0, 1'b1, 2'd1, 1'b0);
        send_cmd(6, disc_cmd(mode_mask(io_pkg::mode_ack_int)), 1'b0, 1'b0, 2'd2, 1'b0);
        send_cmd(7, 16'h0123, 1'b1, 1'b0, 2'd0, 1'b1);    // nop
        send_cmd(8, pio_cmd(io_pkg::unit_group, 9'h1ff), 1'b0, 1'b0, 2'd3, 1'b1);
        send_cmd(9, disc_cmd(mode_mask(io_pkg::mode_mla_clr) | mode_mask(io_pkg::mode_ack_din)),
                 1'b1, 1'b0, 2'd1, 1'b0);

        for (int i = n_directed; i < n_cmds; i++) begin
            rnd = $random(seed);
            send_cmd(i, random_cmd(), rnd[0], rnd[1], rnd[3:2], rnd[6:4] == 3'd0);
        end

        @(negedge sim_clk);
        if (i_io_unit_top.i_io_unit_props.fail_cnt != 0) begin
            stop_on_error("a bound property check failed");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sources.f */
common/io_pkg.sv
design/phase_gen.sv
decode/cmd_field_decode.sv
decode/address_decode.sv
design/io_unit_top.sv
verification/io_unit_props.sv
verification/tb_io_unit.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the io unit regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_io_unit -f sources.f > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "compile failed with status $status"
    exit 1
fi

# keep running past a property error so the testbench can report it
./obj_dir/Vtb_io_unit +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
